// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = 8;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // ALU_ADD is zero so a cleared entry decodes as add
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic [4:0]      rs1_idx;
        logic [4:0]      rs2_idx;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        // operand a from pc, operand b from imm
        logic            src1_pc;
        logic            src2_imm;
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        // funct3 of the branch
        logic [2:0]      br_cond;
        logic            wen;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic            wen;
        logic [XLEN-1:0] result;
    } ex_wb_t;

    typedef struct packed {
        logic            enable;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } rf_write_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic            wen;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        imem_we_i,
    input  logic [rv_pkg::IMEM_AW-1:0]  imem_addr_i,
    input  logic [rv_pkg::XLEN-1:0]     imem_data_i,
    input  rv_pkg::redirect_t           redirect_i,
    output rv_pkg::if_id_t              if_id_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    logic [rv_pkg::XLEN-1:0] fetch_word;
    logic [rv_pkg::XLEN-1:0] imem [rv_pkg::IMEM_DEPTH];

    // load port, one word per edge
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    // word address taken from pc, byte offset ignored
    assign fetch_word = imem[pc_q[rv_pkg::IMEM_AW+1:2]];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= rv_pkg::RESET_PC;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.target;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_o <= '0;
        end else begin
            // wrong-path word becomes a bubble
            if_id_o.valid <= ~redirect_i.valid;
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  rv_pkg::if_id_t          if_id_i,
    input  rv_pkg::redirect_t       redirect_i,
    input  rv_pkg::rf_write_t       rf_write_i,
    output rv_pkg::id_ex_t          id_ex_o,
    output logic [rv_pkg::XLEN-1:0] a0_o
);

    logic [rv_pkg::XLEN-1:0] regs [1:31];
    logic [31:0]             instr;
    rv_pkg::opcode_e         opcode;
    rv_pkg::alu_op_e         alu_fn;
    logic [4:0]              rs1_idx;
    logic [4:0]              rs2_idx;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_j;
    rv_pkg::id_ex_t          dec;

    // x0 reads zero, same-cycle write is bypassed
    function automatic logic [rv_pkg::XLEN-1:0] rf_read(input logic [4:0] idx);
        logic [rv_pkg::XLEN-1:0] val;
        if (idx == 5'd0) begin
            val = '0;
        end else if (rf_write_i.enable && rf_write_i.rd == idx) begin
            val = rf_write_i.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    assign instr   = if_id_i.instr;
    assign opcode  = rv_pkg::opcode_e'(instr[6:0]);
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3/funct7 to ALU function, sub only for register ops
    always_comb begin
        case (instr[14:12])
            3'b000:  alu_fn = (opcode == rv_pkg::OPC_OP && instr[30]) ? rv_pkg::ALU_SUB
                                                                       : rv_pkg::ALU_ADD;
            3'b001:  alu_fn = rv_pkg::ALU_SLL;
            3'b010:  alu_fn = rv_pkg::ALU_SLT;
            3'b011:  alu_fn = rv_pkg::ALU_SLTU;
            3'b100:  alu_fn = rv_pkg::ALU_XOR;
            3'b101:  alu_fn = instr[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_fn = rv_pkg::ALU_OR;
            default: alu_fn = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec         = '0;
        dec.valid   = if_id_i.valid;
        dec.pc      = if_id_i.pc;
        dec.instr   = instr;
        dec.rs1_idx = rs1_idx;
        dec.rs2_idx = rs2_idx;
        dec.rs1_val = rf_read(rs1_idx);
        dec.rs2_val = rf_read(rs2_idx);
        dec.br_cond = instr[14:12];
        case (opcode)
            rv_pkg::OPC_OP: begin
                dec.alu_op = alu_fn;
                dec.wen    = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                dec.alu_op   = alu_fn;
                dec.imm      = imm_i;
                dec.src2_imm = 1'b1;
                dec.wen      = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                dec.alu_op   = rv_pkg::ALU_PASS_B;
                dec.imm      = imm_u;
                dec.src2_imm = 1'b1;
                dec.wen      = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                dec.imm      = imm_u;
                dec.src1_pc  = 1'b1;
                dec.src2_imm = 1'b1;
                dec.wen      = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                dec.wen    = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                dec.imm     = imm_i;
                dec.is_jalr = 1'b1;
                dec.wen     = 1'b1;
            end
            // anything else passes through as a nop
            default: dec.wen = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write_i.enable) begin
            regs[rf_write_i.rd] <= rf_write_i.data;
        end
    end

    assign a0_o = regs[10];

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o       <= dec;
            id_ex_o.valid <= dec.valid & ~redirect_i.valid;
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv_pkg::id_ex_t    id_ex_i,
    input  rv_pkg::rf_write_t rf_write_i,
    output rv_pkg::redirect_t redirect_o,
    output rv_pkg::ex_wb_t    ex_wb_o
);

    logic [rv_pkg::XLEN-1:0] rs1;
    logic [rv_pkg::XLEN-1:0] rs2;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [rv_pkg::XLEN-1:0] jalr_sum;
    logic [rv_pkg::XLEN-1:0] link_pc;
    logic                    br_taken;
    logic                    is_jump;

    // bypass from the instruction one ahead, x0 already filtered out
    assign rs1 = (rf_write_i.enable && rf_write_i.rd == id_ex_i.rs1_idx) ? rf_write_i.data
                                                                          : id_ex_i.rs1_val;
    assign rs2 = (rf_write_i.enable && rf_write_i.rd == id_ex_i.rs2_idx) ? rf_write_i.data
                                                                          : id_ex_i.rs2_val;

    assign op_a = id_ex_i.src1_pc  ? id_ex_i.pc  : rs1;
    assign op_b = id_ex_i.src2_imm ? id_ex_i.imm : rs2;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_pkg::ALU_AND:  alu_res = op_a & op_b;
            rv_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
            rv_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            rv_pkg::ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_res = {31'd0, op_a < op_b};
            default:          alu_res = op_b;
        endcase
    end

    // beq, bne, blt, bge
    always_comb begin
        case (id_ex_i.br_cond)
            3'b000:  br_taken = (rs1 == rs2);
            3'b001:  br_taken = (rs1 != rs2);
            3'b100:  br_taken = ($signed(rs1) < $signed(rs2));
            3'b101:  br_taken = ($signed(rs1) >= $signed(rs2));
            default: br_taken = 1'b0;
        endcase
    end

    assign is_jump  = id_ex_i.is_jal | id_ex_i.is_jalr;
    assign jalr_sum = rs1 + id_ex_i.imm;
    assign link_pc  = id_ex_i.pc + 32'd4;

    assign redirect_o.valid  = id_ex_i.valid & (is_jump | (id_ex_i.is_branch & br_taken));
    assign redirect_o.target = id_ex_i.is_jalr ? {jalr_sum[rv_pkg::XLEN-1:1], 1'b0}
                                               : id_ex_i.pc + id_ex_i.imm;

    // EX/WB register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_wb_o <= '0;
        end else begin
            ex_wb_o.valid  <= id_ex_i.valid;
            ex_wb_o.pc     <= id_ex_i.pc;
            ex_wb_o.instr  <= id_ex_i.instr;
            ex_wb_o.rd     <= id_ex_i.instr[11:7];
            ex_wb_o.wen    <= id_ex_i.wen;
            ex_wb_o.result <= is_jump ? link_pc : alu_res;
        end
    end

endmodule

`default_nettype wire

// ==== design/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  rv_pkg::ex_wb_t    ex_wb_i,
    output rv_pkg::rf_write_t rf_write_o,
    output rv_pkg::retire_t   retire_o
);

    logic commit_wr;

    // only valid entries with a nonzero rd write
    assign commit_wr = ex_wb_i.valid & ex_wb_i.wen & (ex_wb_i.rd != 5'd0);

    assign rf_write_o.enable = commit_wr;
    assign rf_write_o.rd     = ex_wb_i.rd;
    assign rf_write_o.data   = ex_wb_i.result;

    // retirement record, same qualification as the write
    assign retire_o.valid = ex_wb_i.valid;
    assign retire_o.pc    = ex_wb_i.pc;
    assign retire_o.instr = ex_wb_i.instr;
    assign retire_o.wen   = commit_wr;
    assign retire_o.rd    = ex_wb_i.rd;
    assign retire_o.data  = ex_wb_i.result;

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       imem_we_i,
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr_i,
    input  logic [rv_pkg::XLEN-1:0]    imem_data_i,
    output rv_pkg::retire_t            retire_o,
    output logic [rv_pkg::XLEN-1:0]    a0_o
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_wb_t    ex_wb;
    rv_pkg::redirect_t redirect;
    rv_pkg::rf_write_t rf_write;

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .redirect_i  (redirect),
        .if_id_o     (if_id)
    );

    decode_stage decode_stage_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .if_id_i    (if_id),
        .redirect_i (redirect),
        .rf_write_i (rf_write),
        .id_ex_o    (id_ex),
        .a0_o       (a0_o)
    );

    exec_stage exec_stage_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .id_ex_i    (id_ex),
        .rf_write_i (rf_write),
        .redirect_o (redirect),
        .ex_wb_o    (ex_wb)
    );

    writeback_stage writeback_stage_inst (
        .ex_wb_i    (ex_wb),
        .rf_write_o (rf_write),
        .retire_o   (retire_o)
    );

endmodule

`default_nettype wire

// ==== bench/rv_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_props (
    input logic              clk,
    input logic              rst_n_i,
    input rv_pkg::retire_t   retire_i,
    input rv_pkg::redirect_t redirect_i
);

    // nothing retires while reset is held
    assert property (@(posedge clk) !rst_n_i |-> !retire_i.valid)
        else $error("retire valid during reset");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_i.valid |-> !(retire_i.wen && retire_i.rd == 5'd0))
        else $error("retire reports a write to x0");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_i.valid |-> retire_i.pc[1:0] == 2'b00)
        else $error("retire pc not word aligned");

    // the two slots flushed behind a redirect never retire
    assert property (@(posedge clk) disable iff (!rst_n_i)
        ($past(redirect_i.valid, 2) || $past(redirect_i.valid, 3)) |-> !retire_i.valid)
        else $error("flushed instruction retired");

endmodule

`default_nettype wire

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int RETIRE_TIMEOUT = 20;

    logic                       clk;
    logic                       rst_n_i;
    logic                       imem_we_i;
    logic [rv_pkg::IMEM_AW-1:0] imem_addr_i;
    logic [31:0]                imem_data_i;
    rv_pkg::retire_t            retire_o;
    logic [31:0]                a0_o;

    logic [31:0]     prog [rv_pkg::IMEM_DEPTH];
    int              prog_len;
    rv_pkg::retire_t exp_q [$];
    logic [31:0]     exp_a0;
    logic [15:0]     lfsr_state;
    string           test_name;

    rv_core_top rv_core_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .retire_o    (retire_o),
        .a0_o        (a0_o)
    );

    bind rv_core_top rv_core_props rv_core_props_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .retire_i   (retire_o),
        .redirect_i (redirect)
    );

    always #50 clk = ~clk;

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    function automatic void emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = {31'd0, $signed(a) < $signed(b)};
            3'd3:    r = {31'd0, a < b};
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        logic t;
        case (f3)
            3'd0:    t = (a == b);
            3'd1:    t = (a != b);
            3'd4:    t = ($signed(a) < $signed(b));
            3'd5:    t = ($signed(a) >= $signed(b));
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    // instruction-set model, runs until the self-jal halt
    function automatic void model_program();
        logic [31:0]     rf [32];
        logic [31:0]     pc;
        logic [31:0]     ins;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_i;
        logic [31:0]     res;
        logic [31:0]     next_pc;
        logic            wr;
        logic            halt;
        rv_pkg::retire_t rec;
        exp_q.delete();
        for (int r = 0; r < 32; r++) begin
            rf[r] = '0;
        end
        pc   = rv_pkg::RESET_PC;
        halt = 1'b0;
        for (int step = 0; step < 1000 && !halt; step++) begin
            ins     = prog[pc[9:2]];
            a       = rf[ins[19:15]];
            b       = rf[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = '0;
            case (ins[6:0])
                rv_pkg::OPC_OP:     res = alu_ref(ins[14:12], ins[30], a, b);
                rv_pkg::OPC_OP_IMM: res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5,
                                                  a, imm_i);
                rv_pkg::OPC_LUI:    res = {ins[31:12], 12'h000};
                rv_pkg::OPC_AUIPC:  res = pc + {ins[31:12], 12'h000};
                rv_pkg::OPC_BRANCH: begin
                    wr = 1'b0;
                    if (branch_taken(ins[14:12], a, b)) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                rv_pkg::OPC_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                    halt    = (next_pc == pc);
                end
                rv_pkg::OPC_JALR: begin
                    res     = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: wr = 1'b0;
            endcase
            rec.valid = 1'b1;
            rec.pc    = pc;
            rec.instr = ins;
            rec.rd    = ins[11:7];
            rec.wen   = wr && ins[11:7] != 5'd0;
            rec.data  = res;
            if (rec.wen) begin
                rf[rec.rd] = res;
            end
            exp_q.push_back(rec);
            pc = next_pc;
        end
        exp_a0 = rf[10];
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s expected %h actual %h", test_name, field, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // program goes in while reset is low, then reset stays for 8 cycles
    task automatic load_and_reset();
        @(posedge clk);
        rst_n_i <= 1'b0;
        for (int k = 0; k < prog_len; k++) begin
            @(posedge clk);
            imem_we_i   <= 1'b1;
            imem_addr_i <= k[rv_pkg::IMEM_AW-1:0];
            imem_data_i <= prog[k];
            @(negedge clk);
            check_value("valid in reset", 32'd0, 32'(retire_o.valid));
        end
        @(posedge clk);
        imem_we_i <= 1'b0;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            check_value("valid in reset", 32'd0, 32'(retire_o.valid));
        end
        @(posedge clk);
        rst_n_i <= 1'b1;
    endtask

    task automatic compare_retires();
        rv_pkg::retire_t want;
        int              waited;
        while (exp_q.size() > 0) begin
            want   = exp_q.pop_front();
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!retire_o.valid && waited < RETIRE_TIMEOUT);
            if (!retire_o.valid) begin
                $display("core stopped retiring in %s, waiting for pc %h", test_name, want.pc);
                $display("tests failed");
                $fatal(1, "retire timeout");
            end
            check_value("pc", want.pc, retire_o.pc);
            check_value("instr", want.instr, retire_o.instr);
            check_value("wen", 32'(want.wen), 32'(retire_o.wen));
            check_value("rd", 32'(want.rd), 32'(retire_o.rd));
            if (want.wen) begin
                check_value("data", want.data, retire_o.data);
            end
        end
        // halt has retired, a0 settles after its write edge
        repeat (2) @(negedge clk);
        check_value("a0", exp_a0, a0_o);
    endtask

    task automatic run_test(input string name);
        test_name = name;
        model_program();
        load_and_reset();
        compare_retires();
    endtask

    function automatic void build_forwarding();
        prog_len = 0;
        emit(i_type(12'd5, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'd3, 5'd1, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        emit(r_type(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
        // x2 three instructions back
        emit(r_type(7'h00, 5'd4, 5'd2, 3'd4, 5'd5));
        emit(i_type(12'd7, 5'd5, 3'd0, 5'd0, rv_pkg::OPC_OP_IMM));
        emit(r_type(7'h00, 5'd5, 5'd0, 3'd0, 5'd10));
        emit(i_type(12'hff0, 5'd0, 3'd0, 5'd8, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'h402, 5'd8, 3'd5, 5'd9, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'd3, 5'd10, 3'd1, 5'd6, rv_pkg::OPC_OP_IMM));
        emit(r_type(7'h00, 5'd1, 5'd8, 3'd2, 5'd11));
        emit(r_type(7'h00, 5'd1, 5'd8, 3'd3, 5'd12));
        emit(r_type(7'h00, 5'd1, 5'd8, 3'd5, 5'd13));
        emit(r_type(7'h00, 5'd6, 5'd9, 3'd6, 5'd14));
        emit(r_type(7'h00, 5'd14, 5'd13, 3'd7, 5'd15));
        emit(u_type(20'h12345, 5'd16, rv_pkg::OPC_LUI));
        emit(u_type(20'h00001, 5'd17, rv_pkg::OPC_AUIPC));
        emit(r_type(7'h00, 5'd17, 5'd16, 3'd0, 5'd10));
        emit(j_type(21'd0, 5'd0));
    endfunction

    // x1 = 1, x2 = -1, skipped slots add to a0
    function automatic void build_branches();
        prog_len = 0;
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'hfff, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'd0));
        emit(i_type(12'd99, 5'd0, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'd1));
        emit(i_type(12'd1, 5'd10, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(b_type(13'd12, 5'd1, 5'd2, 3'd4));
        emit(i_type(12'd40, 5'd10, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'd80, 5'd10, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd1, 5'd2, 3'd5));
        emit(i_type(12'd2, 5'd10, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd5));
        emit(i_type(12'd50, 5'd10, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd0));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd4));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd1));
        emit(i_type(12'd60, 5'd10, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(j_type(21'd0, 5'd0));
    endfunction

    function automatic void build_jumps();
        prog_len = 0;
        emit(i_type(12'd21, 5'd0, 3'd0, 5'd5, rv_pkg::OPC_OP_IMM));
        emit(j_type(21'd12, 5'd1));
        emit(i_type(12'd77, 5'd0, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'd88, 5'd0, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        // 21 + 3 is even, 41 + 0 is odd
        emit(i_type(12'd3, 5'd5, 3'd0, 5'd2, rv_pkg::OPC_JALR));
        emit(i_type(12'd66, 5'd0, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd10));
        emit(i_type(12'd41, 5'd0, 3'd0, 5'd6, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'd0, 5'd6, 3'd0, 5'd3, rv_pkg::OPC_JALR));
        emit(i_type(12'd55, 5'd0, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(j_type(21'd0, 5'd0));
    endfunction

    function automatic void build_random();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        int          off;
        prog_len = 0;
        for (int i = 0; i < 149; i++) begin
            kind = 3'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            // x0..x15 only, so results get reused often
            rd   = 5'(rand_bits(4));
            rs1  = 5'(rand_bits(4));
            rs2  = 5'(rand_bits(4));
            alt  = lfsr_step();
            imm  = 12'(rand_bits(12));
            off  = 1 + int'(rand_bits(2));
            if (i + off > 149) begin
                off = 149 - i;
            end
            f7 = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0};
            if (f3 == 3'd1) begin
                imm = {7'd0, rs2};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, alt, 5'd0, rs2};
            end
            case (kind)
                3'd0, 3'd1, 3'd2: emit(r_type(f7, rs2, rs1, f3, rd));
                3'd3, 3'd4:       emit(i_type(imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM));
                3'd5: emit(u_type({imm, rs1, rs2[2:0]}, rd,
                                  alt ? rv_pkg::OPC_LUI : rv_pkg::OPC_AUIPC));
                3'd6:    emit(b_type(13'(off * 4), rs2, rs1, {f3[1], 1'b0, f3[0]}));
                default: emit(j_type(21'(off * 4), rd));
            endcase
        end
        emit(j_type(21'd0, 5'd0));
    endfunction

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        imem_we_i   = 1'b0;
        imem_addr_i = '0;
        imem_data_i = '0;
        lfsr_state  = 16'd87;
        prog_len    = 0;
        build_forwarding();
        run_test("reset_forwarding");
        build_branches();
        run_test("branches");
        build_jumps();
        run_test("jumps");
        build_random();
        run_test("random_program");
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/rv_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/exec_stage.sv
design/writeback_stage.sv
design/rv_core_top.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module rv_core_tb -o rv_core_sim \
    && ./obj_dir/rv_core_sim \
    || { echo "simulation did not pass"; exit 1; }
